// ==== Makefile ====
# Verilator build of the width-converter bank testbench.

VERILATOR ?= verilator
TOP       ?= tb_conv_dw_bank
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation PASSED"; \
	else \
	  echo "simulation FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/dw_cfg_pkg.sv ====
package dw_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // member geometry
  ////////////////////////////////////////////////////////////

  localparam int COPIES  = 2;  // kernel copies folded into one member.
  localparam int GROUPS  = 2;  // output groups per member.
  localparam int UNITS   = 2;  // spatial units per member.
  localparam int MEMBERS = 8;  // members in one accumulator beat.

  ////////////////////////////////////////////////////////////
  // width conversion
  ////////////////////////////////////////////////////////////

  localparam int DW_K      = 2;             // first stage splits the beat this many ways.
  localparam int SUB_CORES = MEMBERS / DW_K;  // members left in each first-stage lane.

  ////////////////////////////////////////////////////////////
  // bit widths
  ////////////////////////////////////////////////////////////

  localparam int WORD_W           = 16;  // accumulator word.
  localparam int USER_W           = 4;   // activation code carried with each member.
  localparam int WORDS_PER_MEMBER = COPIES * GROUPS * UNITS;
  localparam int MEMBER_W         = WORDS_PER_MEMBER * WORD_W;
  localparam int IN_DATA_W        = MEMBERS * MEMBER_W;
  localparam int IN_USER_W        = MEMBERS * USER_W;

endpackage

// ==== common/dw_types_pkg.sv ====
package dw_types_pkg;

  import dw_cfg_pkg::*;

  ////////////////////////////////////////////////////////////
  // payload types
  ////////////////////////////////////////////////////////////

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [MEMBER_W-1:0]  member_t;
  typedef logic [USER_W-1:0]    user_t;

  // a full input beat, member 0 in the low bits.
  typedef logic [IN_DATA_W-1:0] in_data_t;
  typedef logic [IN_USER_W-1:0] in_user_t;
  typedef logic [MEMBERS-1:0]   in_keep_t;

  ////////////////////////////////////////////////////////////
  // control types
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    DW_EMPTY,   // nothing stored, ready for a new beat.
    DW_SERIAL   // a beat is stored and lanes are being sent.
  } dw_state_e;

endpackage

// ==== compile.f ====
common/dw_cfg_pkg.sv
common/dw_types_pkg.sv
dw_bank/dw_downsizer.sv
dw_bank/dw_keep_slice.sv
dw_bank/conv_dw_bank.sv
sim/tb_conv_dw_bank.sv

// ==== dw_bank/conv_dw_bank.sv ====
`timescale 1ns/1ps

module conv_dw_bank
  import dw_cfg_pkg::*;
  import dw_types_pkg::*;
(
  input  logic     aclk,
  input  logic     arst_n,

  input  logic     s_valid,
  input  logic     s_last,
  output logic     s_ready,
  input  in_data_t s_data,
  input  in_user_t s_user,
  input  in_keep_t s_keep,

  input  logic     m_ready,
  output logic     m_valid,
  output logic     m_last,
  output member_t  m_data,
  output user_t    m_user
);

  in_data_t k_data;  // lane k, position s holds member s*DW_K+k.
  in_user_t k_user;
  in_keep_t k_keep;

  logic                          k_valid, k_ready, k_last;
  logic [SUB_CORES*MEMBER_W-1:0] k_m_data;
  logic [SUB_CORES*USER_W-1:0]   k_m_user;
  logic [SUB_CORES-1:0]          k_m_keep;

  logic    r_valid, r_ready, r_last, r_keep;
  member_t r_data;
  user_t   r_user;

  ////////////////////////////////////////////////////////////
  // member regrouping
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < DW_K; k++) begin : g_lane
    for (genvar s = 0; s < SUB_CORES; s++) begin : g_pos
      assign k_data[(k*SUB_CORES+s)*MEMBER_W +: MEMBER_W] = s_data[(s*DW_K+k)*MEMBER_W +: MEMBER_W];
      assign k_user[(k*SUB_CORES+s)*USER_W +: USER_W]     = s_user[(s*DW_K+k)*USER_W +: USER_W];
      assign k_keep[k*SUB_CORES+s]                        = s_keep[s*DW_K+k];
    end
  end

  ////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////

  dw_downsizer #(
    .RATIO    (DW_K),
    .LANE_W   (SUB_CORES * MEMBER_W),
    .USER_W_L (SUB_CORES * USER_W),
    .KEEP_W_L (SUB_CORES)
  ) stage_k (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_ready (s_ready),
    .s_data  (k_data),
    .s_user  (k_user),
    .s_keep  (k_keep),
    .m_ready (k_ready),
    .m_valid (k_valid),
    .m_last  (k_last),
    .m_data  (k_m_data),
    .m_user  (k_m_user),
    .m_keep  (k_m_keep)
  );

  dw_downsizer #(
    .RATIO    (SUB_CORES),
    .LANE_W   (MEMBER_W),
    .USER_W_L (USER_W),
    .KEEP_W_L (1)
  ) stage_r (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (k_valid),
    .s_last  (k_last),
    .s_ready (k_ready),
    .s_data  (k_m_data),
    .s_user  (k_m_user),
    .s_keep  (k_m_keep),
    .m_ready (r_ready),
    .m_valid (r_valid),
    .m_last  (r_last),
    .m_data  (r_data),
    .m_user  (r_user),
    .m_keep  (r_keep)
  );

  dw_keep_slice out_slice (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (r_valid),
    .s_last  (r_last),
    .s_keep  (r_keep),
    .s_ready (r_ready),
    .s_data  (r_data),
    .s_user  (r_user),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_user  (m_user)
  );

endmodule

// ==== dw_bank/dw_downsizer.sv ====
`timescale 1ns/1ps

module dw_downsizer
  import dw_cfg_pkg::*;
  import dw_types_pkg::*;
#(
  parameter int RATIO    = DW_K,
  parameter int LANE_W   = SUB_CORES * MEMBER_W,
  parameter int USER_W_L = SUB_CORES * USER_W,
  parameter int KEEP_W_L = SUB_CORES
) (
  input  logic                      aclk,
  input  logic                      arst_n,

  input  logic                      s_valid,
  input  logic                      s_last,
  output logic                      s_ready,
  input  logic [RATIO*LANE_W-1:0]   s_data,
  input  logic [RATIO*USER_W_L-1:0] s_user,
  input  logic [RATIO*KEEP_W_L-1:0] s_keep,

  input  logic                      m_ready,
  output logic                      m_valid,
  output logic                      m_last,
  output logic [LANE_W-1:0]         m_data,
  output logic [USER_W_L-1:0]       m_user,
  output logic [KEEP_W_L-1:0]       m_keep
);

  localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  dw_state_e                 state_q;
  logic [CNT_W-1:0]          cnt_q;
  logic [RATIO*LANE_W-1:0]   data_q;
  logic [RATIO*USER_W_L-1:0] user_q;
  logic [RATIO*KEEP_W_L-1:0] keep_q;
  logic                      last_q;

  logic last_lane;
  logic m_fire;
  logic s_fire;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  assign last_lane = (cnt_q == CNT_W'(RATIO - 1));
  assign m_valid   = (state_q == DW_SERIAL);
  assign m_fire    = m_valid && m_ready;
  assign s_ready   = (state_q == DW_EMPTY) || (m_fire && last_lane);  // no bubble between beats.
  assign s_fire    = s_valid && s_ready;

  ////////////////////////////////////////////////////////////
  // lane select
  ////////////////////////////////////////////////////////////

  assign m_data = data_q[cnt_q*LANE_W +: LANE_W];
  assign m_user = user_q[cnt_q*USER_W_L +: USER_W_L];
  assign m_keep = keep_q[cnt_q*KEEP_W_L +: KEEP_W_L];
  assign m_last = last_q && last_lane;  // only the final lane closes a packet.

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= DW_EMPTY;
      cnt_q   <= '0;
    end else if (s_fire) begin
      state_q <= DW_SERIAL;  // the first lane shows up next cycle.
      cnt_q   <= '0;
    end else if (m_fire) begin
      if (last_lane) begin
        state_q <= DW_EMPTY;
        cnt_q   <= '0;
      end else begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_fire) begin
      data_q <= s_data;
      user_q <= s_user;
      keep_q <= s_keep;
      last_q <= s_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a stalled lane must stay on offer until the next stage takes it.
  a_valid_hold: assert property (
    @(posedge aclk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid
  ) else $error("dw_downsizer m_valid dropped without a transfer.");

  a_cnt_range: assert property (
    @(posedge aclk) disable iff (!arst_n)
    int'(cnt_q) < RATIO
  ) else $error("dw_downsizer lane counter out of range.");

endmodule

// ==== dw_bank/dw_keep_slice.sv ====
`timescale 1ns/1ps

module dw_keep_slice
  import dw_types_pkg::*;
(
  input  logic    aclk,
  input  logic    arst_n,

  input  logic    s_valid,
  input  logic    s_last,
  input  logic    s_keep,
  output logic    s_ready,
  input  member_t s_data,
  input  user_t   s_user,

  input  logic    m_ready,
  output logic    m_valid,
  output logic    m_last,
  output member_t m_data,
  output user_t   m_user
);

  logic    valid_q;
  logic    last_q;
  member_t data_q;
  user_t   user_q;
  logic    load;

  assign s_ready = !valid_q || m_ready;
  assign load    = s_valid && s_ready && s_keep;  // keep-low members are taken and thrown away.

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (s_ready) begin
      valid_q <= load;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      data_q <= s_data;
      user_q <= s_user;  // each member keeps its own activation code.
      last_q <= s_last;
    end
  end

  assign m_valid = valid_q;
  assign m_last  = last_q;
  assign m_data  = data_q;
  assign m_user  = user_q;

  // the member that carries last comes from the top input. dropping it would lose the packet end.
  a_last_kept: assert property (
    @(posedge aclk) disable iff (!arst_n)
    s_valid && s_ready && s_last |-> s_keep
  ) else $error("dw_keep_slice last member arrived with keep low.");

endmodule

// ==== sim/tb_conv_dw_bank.sv ====
`timescale 1ns/1ps

module tb_conv_dw_bank
  import dw_cfg_pkg::*;
  import dw_types_pkg::*;
();

  localparam int NUM_BEATS      = 2000;
  localparam int DIRECTED_BEATS = 200;  // full keep, no gaps and no stalls for the first beats.
  localparam int RESET_CYCLES   = 10;
  localparam int DRAIN_IDLE     = 20;
  localparam int DRAIN_LIMIT    = DRAIN_IDLE + 4 * MEMBERS;
  localparam int TIMEOUT_CYCLES = NUM_BEATS * MEMBERS * 4;

  logic     aclk;
  logic     arst_n;
  logic     s_valid;
  logic     s_last;
  logic     s_ready;
  in_data_t s_data;
  in_user_t s_user;
  in_keep_t s_keep;
  logic     m_ready;
  logic     m_valid;
  logic     m_last;
  member_t  m_data;
  user_t    m_user;

  logic [31:0] rng_state;
  member_t     exp_data[$];
  user_t       exp_user[$];
  logic        exp_last[$];
  int          beats_made;
  int          beats_sent;
  int          members_seen;
  int          cycle_cnt;
  logic        in_fire;

  conv_dw_bank dut0 (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_user  (s_user),
    .s_keep  (s_keep),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_data  (m_data),
    .m_user  (m_user)
  );

  always #2 aclk = ~aclk;

  ////////////////////////////////////////////////////////////
  // random numbers and checks
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() >> 16) % n;  // the upper bits have the longer period.
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failing check.");
  endtask

  task automatic check_data(input member_t exp, input member_t act);
    if (act !== exp) begin
      $display("[ERROR] m_data expected 0x%h got 0x%h", exp, act);
      abort_run();
    end
  endtask

  task automatic check_user(input user_t exp, input user_t act);
    if (act !== exp) begin
      $display("[ERROR] m_user expected 0x%h got 0x%h", exp, act);
      abort_run();
    end
  endtask

  task automatic check_last(input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] m_last expected 0x%h got 0x%h", exp, act);
      abort_run();
    end
  endtask

  task automatic check_ctrl(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////////////////////////

  task automatic make_beat(input bit directed);
    int density;
    density = directed ? 0 : rand_below(4);  // higher density drops more members.
    for (int w = 0; w < IN_DATA_W / WORD_W; w++) begin
      s_data[w*WORD_W +: WORD_W] = word_t'(next_rand() >> 16);
    end
    for (int m = 0; m < MEMBERS; m++) begin
      s_user[m*USER_W +: USER_W] = user_t'(next_rand() >> 20);
      s_keep[m] = (rand_below(4) >= density);
    end
    s_last = (beats_made == NUM_BEATS - 1) || (rand_below(4) == 0);
    if (s_last) begin
      s_keep[MEMBERS-1] = 1'b1;  // the member that closes a packet is never dropped.
    end
  endtask

  // members leave split index outer and sub-core index inner.
  task automatic push_model();
    int m;
    int pushed;
    pushed = 0;
    for (int k = 0; k < DW_K; k++) begin
      for (int s = 0; s < SUB_CORES; s++) begin
        m = s * DW_K + k;
        if (s_keep[m]) begin
          exp_data.push_back(s_data[m*MEMBER_W +: MEMBER_W]);
          exp_user.push_back(s_user[m*USER_W +: USER_W]);
          exp_last.push_back(1'b0);
          pushed++;
        end
      end
    end
    if (s_last && pushed > 0) begin
      exp_last[exp_last.size()-1] = 1'b1;
    end
  endtask

  task automatic check_output();
    if (exp_data.size() == 0) begin
      $display("output member %0d arrived while no member was expected.", members_seen);
      abort_run();
    end else begin
      check_data(exp_data.pop_front(), m_data);
      check_user(exp_user.pop_front(), m_user);
      check_last(exp_last.pop_front(), m_last);
      members_seen++;
    end
  endtask

  task automatic drive_cycle();
    bit directed;
    directed = (beats_made < DIRECTED_BEATS);
    m_ready  = directed ? 1'b1 : (rand_below(10) >= 3);
    if (!s_valid || in_fire) begin  // a beat on offer stays until it is taken.
      if (beats_made < NUM_BEATS && (directed || rand_below(4) != 0)) begin
        make_beat(directed);
        s_valid = 1'b1;
        beats_made++;
      end else begin
        s_valid = 1'b0;
      end
    end
  endtask

  task automatic sample_cycle();
    in_fire = s_valid && s_ready;
    if (in_fire) begin
      push_model();
      beats_sent++;
    end
    if (m_valid && m_ready) begin
      check_output();
    end
  endtask

  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    int idle;
    int waited;
    aclk         = 1'b0;
    arst_n       = 1'b0;
    s_valid      = 1'b0;
    s_last       = 1'b0;
    s_data       = '0;
    s_user       = '0;
    s_keep       = '0;
    m_ready      = 1'b0;
    rng_state    = 32'hd5b7_eb78;
    beats_made   = 0;
    beats_sent   = 0;
    members_seen = 0;
    cycle_cnt    = 0;
    in_fire      = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge aclk);
      if (i > 0) begin
        check_ctrl("m_valid", 1'b0, m_valid);
        check_ctrl("s_ready", 1'b1, s_ready);
      end
    end
    arst_n = 1'b1;
    @(negedge aclk);
    check_ctrl("m_valid", 1'b0, m_valid);
    check_ctrl("s_ready", 1'b1, s_ready);
    while (beats_sent < NUM_BEATS) begin
      drive_cycle();
      @(posedge aclk);
      sample_cycle();
      @(negedge aclk);
    end
    idle   = 0;
    waited = 0;
    while (idle < DRAIN_IDLE && waited < DRAIN_LIMIT) begin
      s_valid = 1'b0;
      m_ready = 1'b1;
      @(posedge aclk);
      sample_cycle();
      @(negedge aclk);
      waited++;
      if (exp_data.size() == 0) begin
        idle++;  // extra cycles catch any member beyond the model.
      end
    end
    $display("%0d beats sent, %0d members checked.", beats_sent, members_seen);
    if (exp_data.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("%0d expected members never came out.", exp_data.size());
      abort_run();
    end
  end

endmodule
